// File: rv32i_types.sv
package rv32i_types;

typedef logic [31:0] rv32i_word;

// Byte position inside a 32-byte line
typedef struct packed {
	logic [2:0] word_sel;   // Word within the line
	logic [1:0] byte_off;
} rv32i_offset_t;

typedef struct packed {
	logic [23:0]   tag;
	logic [2:0]    index;
	rv32i_offset_t offset;
} rv32i_addr_fields_t;

// One address word, seen raw or split into cache fields
typedef union packed {
	rv32i_word          raw;
	rv32i_addr_fields_t fields;
} rv32i_addr_u;

endpackage : rv32i_types

// File: cache_types.sv
package cache_types;

// Geometry of the two-way instruction cache
localparam int s_offset = 5;
localparam int s_index  = 3;
localparam int s_tag    = 32 - s_offset - s_index;
localparam int s_mask   = 2**s_offset;   // Bytes per line
localparam int s_line   = 8*s_mask;
localparam int num_sets = 2**s_index;
localparam int num_ways = 2;

typedef logic [s_line-1:0] cache_line_t;

// Request as it travels down the pipeline
typedef struct packed {
	rv32i_types::rv32i_word address;
	logic                   mem_read;
	logic                   mem_write;
	logic [3:0]             mem_byte_enable;
	rv32i_types::rv32i_word mem_wdata;
} cache_cw_t;

// Source of the line that feeds word select
typedef enum logic {
	data          = 1'b0,   // Line from the hit way
	pmem_rdata256 = 1'b1    // Line arriving from memory
} rdata_sel_e;

endpackage : cache_types

// File: array.sv
`timescale 1ns/1ps

module array #(
	parameter int width = 1
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            load,
	input  logic                            read,
	input  logic [cache_types::s_index-1:0] rindex,
	input  logic [cache_types::s_index-1:0] windex,
	input  logic [width-1:0]                datain,
	output logic [width-1:0]                dataout
);

	logic [width-1:0] data [cache_types::num_sets];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < cache_types::num_sets; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (load) begin
				data[windex] <= datain;
			end
			if (read) begin
				// Same-set write in this cycle wins over the stored entry
				if (load && (rindex == windex)) begin
					dataout <= datain;
				end else begin
					dataout <= data[rindex];
				end
			end
		end
	end

endmodule : array

// File: icache_dp.sv
`timescale 1ns/1ps

module icache_dp (
	input  logic                      clk,
	input  logic                      arst_n,
	input  cache_types::cache_line_t  pmem_rdata,
	input  rv32i_types::rv32i_word    mem_address,
	input  logic                      mem_read,
	input  logic                      load_lru,
	input  logic [1:0]                load_data,
	input  logic [1:0]                load_tag,
	input  logic                      set_valid1,
	input  logic                      set_valid0,
	input  logic                      read_data,
	input  logic                      addr_sel,
	input  logic                      load_pipeline,
	input  cache_types::rdata_sel_e   rdata_sel,
	output rv32i_types::rv32i_word    mem_rdata,
	output rv32i_types::rv32i_word    pmem_address,
	output logic                      hit,
	output logic                      lru_out,
	output logic                      tag1_hit,
	output logic                      tag0_hit
);

	cache_types::cache_cw_t          cache_cw;
	cache_types::cache_cw_t          pipe_cache_cw;
	rv32i_types::rv32i_addr_u        cpu_addr;
	rv32i_types::rv32i_addr_u        pipe_addr;
	logic [cache_types::s_index-1:0] index;
	cache_types::cache_line_t        data_out [cache_types::num_ways];
	logic [cache_types::s_tag-1:0]   tag_out [cache_types::num_ways];
	logic                            valid_out1;
	logic                            valid_out0;
	logic                            lru_in;
	cache_types::cache_line_t        sel_line;

	assign cpu_addr.raw  = mem_address;
	assign pipe_addr.raw = pipe_cache_cw.address;

	// Stall keeps the arrays pointed at the set held in stage 2
	assign index = addr_sel ? pipe_addr.fields.index : cpu_addr.fields.index;

	// Read-only cache, write side of the control word tied off
	assign cache_cw.address         = mem_address;
	assign cache_cw.mem_read        = mem_read;
	assign cache_cw.mem_write       = 1'b0;
	assign cache_cw.mem_byte_enable = 4'b0;
	assign cache_cw.mem_wdata       = 32'b0;

	for (genvar w = 0; w < cache_types::num_ways; w++) begin : g_way
		array #(.width(cache_types::s_line)) line_array (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (load_data[w]),
			.read    (read_data),
			.rindex  (index),
			.windex  (pipe_addr.fields.index),
			.datain  (pmem_rdata),
			.dataout (data_out[w])
		);

		array #(.width(cache_types::s_tag)) tag_array (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (load_tag[w]),
			.read    (read_data),
			.rindex  (index),
			.windex  (pipe_addr.fields.index),
			.datain  (pipe_addr.fields.tag),
			.dataout (tag_out[w])
		);
	end

	array #(.width(1)) valid1 (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (set_valid1),
		.read    (1'b1),
		.rindex  (index),
		.windex  (pipe_addr.fields.index),
		.datain  (1'b1),
		.dataout (valid_out1)
	);

	array #(.width(1)) valid0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (set_valid0),
		.read    (1'b1),
		.rindex  (index),
		.windex  (pipe_addr.fields.index),
		.datain  (1'b1),
		.dataout (valid_out0)
	);

	array #(.width(1)) lru (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (load_lru),
		.read    (1'b1),
		.rindex  (index),
		.windex  (pipe_addr.fields.index),
		.datain  (lru_in),
		.dataout (lru_out)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_cache_cw <= '0;
		end else if (load_pipeline) begin
			pipe_cache_cw <= cache_cw;
		end
	end

	// Stage 2 compare against the held request
	assign tag1_hit = pipe_cache_cw.mem_read && valid_out1
		&& (tag_out[1] == pipe_addr.fields.tag);
	assign tag0_hit = pipe_cache_cw.mem_read && valid_out0
		&& (tag_out[0] == pipe_addr.fields.tag);
	assign hit = tag1_hit || tag0_hit;

	assign lru_in = hit ? tag0_hit : ~lru_out;   // Refill flips the victim

	assign pmem_address = {pipe_addr.fields.tag, pipe_addr.fields.index,
		{cache_types::s_offset{1'b0}}};

	always_comb begin
		unique case (rdata_sel)
			cache_types::data:          sel_line = tag1_hit ? data_out[1] : data_out[0];
			cache_types::pmem_rdata256: sel_line = pmem_rdata;
		endcase
	end

	assign mem_rdata = sel_line[32*pipe_addr.fields.offset.word_sel +: 32];

	// A set never holds the same tag in both ways
	assert property (@(posedge clk) disable iff (!arst_n) !(tag0_hit && tag1_hit));

endmodule : icache_dp

// File: icache_control.sv
`timescale 1ns/1ps

module icache_control (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    mem_read,
	input  logic                    hit,
	input  logic                    tag1_hit,
	input  logic                    tag0_hit,
	input  logic                    lru_out,
	input  logic                    pmem_resp,
	output logic                    mem_resp,
	output logic                    pmem_read,
	output logic                    load_pipeline,
	output logic                    read_data,
	output logic                    addr_sel,
	output logic [1:0]              load_data,
	output logic [1:0]              load_tag,
	output logic                    set_valid1,
	output logic                    set_valid0,
	output logic                    load_lru,
	output cache_types::rdata_sel_e rdata_sel
);

	typedef enum logic {
		compare,
		fetch
	} state_e;

	state_e     state;
	state_e     next_state;
	logic       pipe_valid;   // Stage 2 holds a read
	logic       miss;
	logic [1:0] victim;

	assign miss   = pipe_valid && !hit;
	assign victim = lru_out ? 2'b10 : 2'b01;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= compare;
			pipe_valid <= 1'b0;
		end else begin
			state <= next_state;
			if (load_pipeline) begin
				pipe_valid <= mem_read;
			end
		end
	end

	always_comb begin
		next_state    = state;
		mem_resp      = 1'b0;
		pmem_read     = 1'b0;
		load_pipeline = 1'b0;
		read_data     = 1'b0;
		addr_sel      = 1'b0;
		load_data     = 2'b00;
		load_tag      = 2'b00;
		set_valid1    = 1'b0;
		set_valid0    = 1'b0;
		load_lru      = 1'b0;
		rdata_sel     = cache_types::data;
		unique case (state)
			compare: begin
				if (miss) begin
					pmem_read  = 1'b1;   // Freeze stage 2, start the line fetch
					addr_sel   = 1'b1;
					next_state = fetch;
				end else begin
					load_pipeline = mem_read || pipe_valid;
					read_data     = mem_read || pipe_valid;
					mem_resp      = hit;
					// Only write when the bit must point elsewhere
					load_lru      = (tag0_hit && !lru_out) || (tag1_hit && lru_out);
				end
			end
			fetch: begin
				pmem_read = 1'b1;
				rdata_sel = cache_types::pmem_rdata256;
				if (pmem_resp) begin
					mem_resp      = 1'b1;
					load_data     = victim;
					load_tag      = victim;
					set_valid1    = victim[1];
					set_valid0    = victim[0];
					load_lru      = 1'b1;
					load_pipeline = 1'b1;   // Next request enters with the refill
					read_data     = 1'b1;
					next_state    = compare;
				end else begin
					addr_sel = 1'b1;
				end
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		pmem_read && !pmem_resp |=> pmem_read);

	assert property (@(posedge clk) disable iff (!arst_n) $onehot0(load_data));

	// CPU holds its request until answered
	assert property (@(posedge clk) disable iff (!arst_n) mem_resp |-> mem_read);

endmodule : icache_control

// File: icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     mem_read,
	input  rv32i_types::rv32i_word   mem_address,
	output logic                     mem_resp,
	output rv32i_types::rv32i_word   mem_rdata,
	output logic                     pmem_read,
	output rv32i_types::rv32i_word   pmem_address,
	input  logic                     pmem_resp,
	input  cache_types::cache_line_t pmem_rdata
);

	logic                    load_pipeline;
	logic                    read_data;
	logic                    addr_sel;
	logic [1:0]              load_data;
	logic [1:0]              load_tag;
	logic                    set_valid1;
	logic                    set_valid0;
	logic                    load_lru;
	cache_types::rdata_sel_e rdata_sel;
	logic                    hit;
	logic                    tag1_hit;
	logic                    tag0_hit;
	logic                    lru_out;

	icache_control control (
		.clk, .arst_n, .mem_read, .hit, .tag1_hit, .tag0_hit, .lru_out, .pmem_resp,
		.mem_resp, .pmem_read, .load_pipeline, .read_data, .addr_sel,
		.load_data, .load_tag, .set_valid1, .set_valid0, .load_lru, .rdata_sel
	);

	icache_dp datapath (
		.clk, .arst_n, .pmem_rdata, .mem_address, .mem_read,
		.load_lru, .load_data, .load_tag, .set_valid1, .set_valid0,
		.read_data, .addr_sel, .load_pipeline, .rdata_sel,
		.mem_rdata, .pmem_address, .hit, .lru_out, .tag1_hit, .tag0_hit
	);

endmodule : icache

// File: pmem_model.sv
`timescale 1ns/1ps

module pmem_model (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     pmem_read,
	input  cache_types::cache_line_t fill_line,   // Line for the current pmem_address
	output logic                     pmem_resp,
	output cache_types::cache_line_t pmem_rdata
);

	int   seed;
	int   wait_cycles;
	logic busy;

	initial begin
		seed        = 32'h097b_93b7;
		pmem_resp   = 1'b0;
		pmem_rdata  = '0;
		busy        = 1'b0;
		wait_cycles = 0;
	end

	// Inputs of the cache change on the falling edge only
	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pmem_resp = 1'b0;
			busy      = 1'b0;
		end else if (pmem_resp) begin
			pmem_resp = 1'b0;   // One-cycle pulse
			busy      = 1'b0;
		end else if (busy) begin
			if (wait_cycles <= 1) begin
				pmem_resp  = 1'b1;
				pmem_rdata = fill_line;
			end else begin
				wait_cycles--;
			end
		end else if (pmem_read) begin
			busy        = 1'b1;
			wait_cycles = 2 + (($random(seed) & 32'h7fff_ffff) % 5);
		end
	end

endmodule : pmem_model

// File: icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

	logic                     clk;
	logic                     arst_n;
	logic                     mem_read;
	rv32i_types::rv32i_word   mem_address;
	logic                     mem_resp;
	rv32i_types::rv32i_word   mem_rdata;
	logic                     pmem_read;
	rv32i_types::rv32i_word   pmem_address;
	logic                     pmem_resp;
	cache_types::cache_line_t pmem_rdata;
	cache_types::cache_line_t fill_line;

	int  seed;
	int  data_errors;
	int  miss_errors;
	int  proto_errors;
	int  timeout_errors;
	bit  hung;

	// Shadow of the cache contents
	logic [23:0] sh_tag [8][2];
	logic        sh_valid [8][2];
	logic        sh_lru [8];   // Next victim way

	rv32i_types::rv32i_word req_q[$];
	int                     exp_q[$];   // 1 miss, 0 hit, -1 left to the shadow
	bit                     saw_pmem;
	int                     resp_pulses;

	logic [23:0] tag_pool [3];

	icache uut (
		.clk, .arst_n, .mem_read, .mem_address, .mem_resp, .mem_rdata,
		.pmem_read, .pmem_address, .pmem_resp, .pmem_rdata
	);

	pmem_model mem (
		.clk, .arst_n, .pmem_read, .fill_line, .pmem_resp, .pmem_rdata
	);

	always #50 clk = ~clk;

	function automatic rv32i_types::rv32i_word ref_word(rv32i_types::rv32i_word addr);
		rv32i_types::rv32i_word w;
		w = addr >> 2;
		return (w * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic cache_types::cache_line_t ref_line(rv32i_types::rv32i_word addr);
		cache_types::cache_line_t line;
		rv32i_types::rv32i_addr_u a;
		a.raw = addr;
		for (int i = 0; i < 8; i++) begin
			a.fields.offset.word_sel = 3'(i);
			a.fields.offset.byte_off = 2'b00;
			line[32*i +: 32] = ref_word(a.raw);
		end
		return line;
	endfunction

	function automatic rv32i_types::rv32i_word make_addr(logic [23:0] tag, int index, int word);
		rv32i_types::rv32i_addr_u a;
		a.fields.tag             = tag;
		a.fields.index           = 3'(index);
		a.fields.offset.word_sel = 3'(word);
		a.fields.offset.byte_off = 2'b00;
		return a.raw;
	endfunction

	assign fill_line = ref_line(pmem_address);

	// Issue one read and hold it until answered
	task automatic do_read(rv32i_types::rv32i_word addr, int exp_miss);
		int cycles;
		if (hung) begin
			return;
		end
		mem_read    = 1'b1;
		mem_address = addr;
		req_q.push_back(addr);
		exp_q.push_back(exp_miss);
		cycles = 0;
		do begin
			@(negedge clk);
			#1;   // Let a refill pulse from the same edge settle
			cycles++;
		end while (!mem_resp && cycles < 40);
		if (!mem_resp) begin
			timeout_errors++;
			hung = 1'b1;
			$display("timeout: no response for address %h at %0t", addr, $time);
		end else if (exp_miss == 0) begin
			assert (cycles == 1) else begin
				proto_errors++;
				$display("hit on address %h took %0d cycles instead of one", addr, cycles);
			end
		end
	endtask

	// Compare every response with the reference and the shadow
	always @(posedge clk) begin : check
		rv32i_types::rv32i_addr_u a;
		int                       way;
		int                       expm;
		bit                       pred_miss;
		rv32i_types::rv32i_word   expw;
		if (!arst_n) begin
			assert (!mem_resp && !pmem_read) else begin
				proto_errors++;
				$display("cache output active during reset at %0t", $time);
			end
			for (int s = 0; s < 8; s++) begin
				sh_valid[s][0] = 1'b0;
				sh_valid[s][1] = 1'b0;
				sh_lru[s]      = 1'b0;
			end
			saw_pmem    = 1'b0;
			resp_pulses = 0;
		end else begin
			if (pmem_resp) begin
				resp_pulses++;
			end
			if (pmem_read) begin
				saw_pmem = 1'b1;
				assert (req_q.size() != 0) else begin
					proto_errors++;
					$display("memory read with no request pending at %0t", $time);
				end
				if (req_q.size() != 0) begin
					assert (pmem_address == {req_q[0][31:5], 5'b0}) else begin
						miss_errors++;
						$display("mismatch %0t pmem_address got %h expected %h", $time,
							pmem_address, {req_q[0][31:5], 5'b0});
					end
				end
			end
			if (mem_resp) begin
				assert (req_q.size() != 0) else begin
					proto_errors++;
					$display("response with no request pending at %0t", $time);
				end
			end
			if (mem_resp && req_q.size() != 0) begin
				a.raw = req_q.pop_front();
				expm  = exp_q.pop_front();
				expw  = ref_word(a.raw);
				assert (mem_rdata == expw) else begin
					data_errors++;
					$display("mismatch %0t mem_rdata got %h expected %h", $time, mem_rdata, expw);
				end
				way = -1;
				for (int w = 0; w < 2; w++) begin
					if (sh_valid[a.fields.index][w]
						&& sh_tag[a.fields.index][w] == a.fields.tag) begin
						way = w;
					end
				end
				pred_miss = (way < 0);
				assert (saw_pmem == pred_miss) else begin
					miss_errors++;
					$display("mismatch %0t pmem_read for %h got %0d expected %0d", $time, a.raw,
						saw_pmem, pred_miss);
				end
				if (expm >= 0) begin
					assert (saw_pmem == expm[0]) else begin
						miss_errors++;
						$display("mismatch %0t scenario pmem_read for %h got %0d expected %0d",
							$time, a.raw, saw_pmem, expm);
					end
				end
				if (saw_pmem) begin
					assert (resp_pulses == 1) else begin
						proto_errors++;
						$display("line fill for %h saw %0d memory responses", a.raw, resp_pulses);
					end
				end
				if (pred_miss) begin
					way = sh_lru[a.fields.index] ? 1 : 0;
					sh_tag[a.fields.index][way]   = a.fields.tag;
					sh_valid[a.fields.index][way] = 1'b1;
				end
				sh_lru[a.fields.index] = (way == 0);   // Other way becomes victim
				saw_pmem    = 1'b0;
				resp_pulses = 0;
			end
		end
	end

	initial begin
		int r;
		seed           = 32'h097b_93b7;
		clk            = 1'b0;
		arst_n         = 1'b0;
		mem_read       = 1'b0;
		mem_address    = '0;
		hung           = 1'b0;
		data_errors    = 0;
		miss_errors    = 0;
		proto_errors   = 0;
		timeout_errors = 0;
		tag_pool[0]    = 24'h000010;
		tag_pool[1]    = 24'h000020;
		tag_pool[2]    = 24'h000030;

		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (3) @(negedge clk);   // Idle, nothing may answer
		#1;

		do_read(make_addr(tag_pool[0], 3, 5), 1);
		for (int w = 0; w < 8; w++) begin
			do_read(make_addr(tag_pool[0], 3, w), 0);
		end

		// Second tag in the same set
		do_read(make_addr(tag_pool[1], 3, 2), 1);
		for (int i = 0; i < 8; i++) begin
			do_read(make_addr(tag_pool[0], 3, i), 0);
			do_read(make_addr(tag_pool[1], 3, 7 - i), 0);
		end

		// Third tag evicts the older one
		do_read(make_addr(tag_pool[2], 3, 0), 1);
		do_read(make_addr(tag_pool[1], 3, 7), 0);
		do_read(make_addr(tag_pool[0], 3, 1), 1);

		for (int n = 0; n < 400; n++) begin
			r = $random(seed) & 32'h7fff_ffff;
			do_read(make_addr(tag_pool[r % 3], (r >> 4) % 4, (r >> 8) % 8), -1);
		end

		@(posedge clk);
		#1;
		$display("errors: data %0d, miss %0d, protocol %0d, timeout %0d",
			data_errors, miss_errors, proto_errors, timeout_errors);
		if (data_errors + miss_errors + proto_errors + timeout_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : icache_tb

// File: sources.f
rv32i_types.sv
cache_types.sv
array.sv
icache_dp.sv
icache_control.sv
icache.sv
pmem_model.sv
icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= icache_tb
FLAGS ?= --binary --timing --assert
OBJ_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
